// ==== project.f ====
+incdir+.
frontPkg.sv
uopPkg.sv
portedStore.sv
flushCtrl.sv
operandLoad.sv
opFetchTop.sv
tb_opFetch.sv

// ==== Bender.yml ====
package:
  name: opFetch

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - frontPkg.sv
      - uopPkg.sv
      - portedStore.sv
      - flushCtrl.sv
      - operandLoad.sv
      - opFetchTop.sv
      - target: test
        files:
          - tb_opFetch.sv

// ==== tb_opFetch.sv ====
`include "opFetch_params.svh"

module tb_opFetch;

    logic             clk;
    logic             rst;
    logic             uopValid[`NUM_PORTS-1:0];
    uopPkg::IssueUop  uop[`NUM_PORTS-1:0];
    logic             stallIn[`NUM_PORTS-1:0];
    logic             wbValid[`NUM_WBS-1:0];
    uopPkg::WbResult  wb[`NUM_WBS-1:0];
    logic             zcValid[`NUM_ZC-1:0];
    uopPkg::Tag       zcTag[`NUM_ZC-1:0];
    logic [31:0]      zcResult[`NUM_ZC-1:0];
    logic             pcWrite;
    frontPkg::FetchId pcWriteAddr;
    frontPkg::PcEntry pcWriteData;
    logic             mispredict;
    uopPkg::SqN       mispredictSqN;
    uopPkg::ExecUop   execUop[`NUM_PORTS-1:0];

    // Shadow copies of both stores
    logic [31:0]      rfShadow[`NUM_REGS-1:0];
    frontPkg::PcEntry pcShadow[`NUM_FETCH-1:0];

    // Stimulus for the next issue cycle and the last expected output
    logic             offerValid[`NUM_PORTS-1:0];
    logic             expectDrop[`NUM_PORTS-1:0];
    uopPkg::IssueUop  offerUop[`NUM_PORTS-1:0];
    uopPkg::ExecUop   lastExp[`NUM_PORTS-1:0];

    integer seed;
    int     errors;
    int     testStartErrors;
    int     testsRun;
    int     testsFailed;

    opFetchTop opFetchTop_inst (
        .clk           (clk),
        .rst           (rst),
        .uopValid      (uopValid),
        .uop           (uop),
        .stallIn       (stallIn),
        .wbValid       (wbValid),
        .wb            (wb),
        .zcValid       (zcValid),
        .zcTag         (zcTag),
        .zcResult      (zcResult),
        .pcWrite       (pcWrite),
        .pcWriteAddr   (pcWriteAddr),
        .pcWriteData   (pcWriteData),
        .mispredict    (mispredict),
        .mispredictSqN (mispredictSqN),
        .execUop       (execUop)
    );

    always #20 clk = ~clk;

    // Outputs must be invalid one cycle after any reset edge
    for (genvar p = 0; p < `NUM_PORTS; p++) begin : gResetCheck
        assert property (@(posedge clk) rst |=> !execUop[p].valid)
            else begin
                $display("[ERROR] reset: port %0d expected valid 0 actual 1", p);
                errors++;
            end
    end

    // Immediate tag, then newest zero-cycle hit, then newest writeback, then storage
    function automatic logic [31:0] operandFor(input uopPkg::Tag tag);
        if (tag[6]) begin
            return 32'($signed(tag[5:0]));
        end
        for (int z = `NUM_ZC - 1; z >= 0; z--) begin
            if (zcValid[z] && zcTag[z] == tag) begin
                return zcResult[z];
            end
        end
        for (int w = `NUM_WBS - 1; w >= 0; w--) begin
            if (wbValid[w] && wb[w].tagDst == tag) begin
                return wb[w].result;
            end
        end
        return rfShadow[tag[5:0]];
    endfunction

    function automatic uopPkg::ExecUop predictUop(input uopPkg::IssueUop u);
        uopPkg::ExecUop   e;
        frontPkg::PcEntry pe;
        pe        = pcShadow[u.fetchID];
        e         = '0;
        e.valid   = 1'b1;
        e.imm     = u.imm;
        e.sqN     = u.sqN;
        e.tagDst  = u.tagDst;
        e.opcode  = u.opcode;
        e.fetchID = u.fetchID;
        e.srcA    = operandFor(u.tagA);
        e.srcB    = u.immB ? u.imm : operandFor(u.tagB);
        // Byte address of the block plus the halfword offset
        e.pc = ((32'(pe.pc) & ~32'd7) << 1) + (32'(u.fetchOffs) << 1);
        if (!u.compressed) begin
            e.pc = e.pc - 32'd2;
        end
        e.history = pe.hist;
        if (pe.bpi.predicted && !pe.bpi.isJump && u.fetchOffs > pe.branchPos) begin
            e.history = (pe.hist << 1) | frontPkg::BHist'(pe.bpi.taken);
        end
        e.bpi = (u.fetchOffs == pe.branchPos) ? pe.bpi : '0;
        return e;
    endfunction

    // Apply this cycle's writes, higher write port last
    task automatic commitShadow();
        for (int w = 0; w < `NUM_WBS; w++) begin
            if (wbValid[w]) begin
                rfShadow[wb[w].tagDst[5:0]] = wb[w].result;
            end
        end
        if (pcWrite) begin
            pcShadow[pcWriteAddr] = pcWriteData;
        end
    endtask

    task automatic clearInputs();
        for (int i = 0; i < `NUM_PORTS; i++) begin
            uopValid[i] = 1'b0;
            stallIn[i]  = 1'b0;
        end
        for (int w = 0; w < `NUM_WBS; w++) begin
            wbValid[w] = 1'b0;
        end
        for (int z = 0; z < `NUM_ZC; z++) begin
            zcValid[z] = 1'b0;
        end
        pcWrite    = 1'b0;
        mispredict = 1'b0;
    endtask

    task automatic tick();
        commitShadow();
        @(negedge clk);
        clearInputs();
    endtask

    task automatic randomUop(output uopPkg::IssueUop u);
        u            = '0;
        u.tagA       = {1'b0, 6'($random(seed))};
        u.tagB       = {1'b0, 6'($random(seed))};
        u.tagDst     = {1'b0, 6'($random(seed))};
        u.sqN        = 7'($random(seed));
        u.imm        = $random(seed);
        u.opcode     = 6'($random(seed));
        u.fetchID    = 4'($random(seed));
        u.fetchOffs  = 3'($random(seed));
        u.compressed = 1'($random(seed));
    endtask

    task automatic randomPcEntry(output frontPkg::PcEntry e);
        logic [63:0] bits;
        bits = {$random(seed), $random(seed)};
        e    = bits[$bits(frontPkg::PcEntry)-1:0];
    endtask

    task automatic checkUop(input string name, input int port, input uopPkg::ExecUop exp);
        assert (execUop[port] === exp)
            else begin
                $display("[ERROR] %s: port %0d expected %h actual %h",
                         name, port, exp, execUop[port]);
                errors++;
            end
    endtask

    task automatic checkValid(input string name, input int port, input logic exp);
        assert (execUop[port].valid === exp)
            else begin
                $display("[ERROR] %s: port %0d expected valid %b actual %b",
                         name, port, exp, execUop[port].valid);
                errors++;
            end
    endtask

    task automatic checkCount(input string name, input int exp, input int act);
        assert (exp == act)
            else begin
                $display("[ERROR] %s: expected %0d actual %0d", name, exp, act);
                errors++;
            end
    endtask

    task automatic waitValid(input string name, input int port);
        int n;
        n = 0;
        while (!execUop[port].valid && n < 20) begin
            @(negedge clk);
            n++;
        end
        if (!execUop[port].valid) begin
            $display("[ERROR] %s: port %0d gave no valid output within 20 cycles", name, port);
            errors++;
        end
    endtask

    task automatic waitRefillDone(input string name);
        int n;
        n = 0;
        while (opFetchTop_inst.stall[0] && n < 20) begin
            @(negedge clk);
            n++;
        end
        if (opFetchTop_inst.stall[0]) begin
            $display("[ERROR] %s: refill stall still active after 20 cycles", name);
            errors++;
        end
    endtask

    // Offer one cycle of uops and check each port's result
    task automatic runIssue(input string name);
        uopPkg::ExecUop expU[`NUM_PORTS-1:0];
        for (int i = 0; i < `NUM_PORTS; i++) begin
            uopValid[i] = offerValid[i];
            uop[i]      = offerUop[i];
            expU[i]     = predictUop(offerUop[i]);
        end
        commitShadow();
        @(negedge clk);
        clearInputs();
        for (int i = 0; i < `NUM_PORTS; i++) begin
            if (offerValid[i] && expectDrop[i]) begin
                checkValid(name, i, 1'b0);
            end else if (offerValid[i]) begin
                waitValid(name, i);
                checkUop(name, i, expU[i]);
                lastExp[i] = expU[i];
            end
            offerValid[i] = 1'b0;
            expectDrop[i] = 1'b0;
        end
    endtask

    task automatic offerRandomAll();
        for (int i = 0; i < `NUM_PORTS; i++) begin
            randomUop(offerUop[i]);
            offerValid[i] = 1'b1;
        end
    endtask

    task automatic reportTest(input string name);
        testsRun++;
        if (errors != testStartErrors) begin
            testsFailed++;
            $display("test %-16s fail (%0d errors)", name, errors - testStartErrors);
        end else begin
            $display("test %-16s ok", name);
        end
        testStartErrors = errors;
    endtask

    task automatic fillStores();
        for (int r = 0; r < `NUM_REGS / 2; r++) begin
            wbValid[0]   = 1'b1;
            wb[0].tagDst = 7'(r);
            wb[0].result = $random(seed);
            wbValid[1]   = 1'b1;
            wb[1].tagDst = 7'(r + `NUM_REGS / 2);
            wb[1].result = $random(seed);
            if (r < `NUM_FETCH) begin
                pcWrite     = 1'b1;
                pcWriteAddr = 4'(r);
                randomPcEntry(pcWriteData);
            end
            tick();
        end
    endtask

    task automatic testRegRead();
        uopPkg::RegId r;
        for (int k = 0; k < 8; k++) begin
            r            = 6'($random(seed));
            wbValid[0]   = 1'b1;
            wb[0].tagDst = {1'b0, r};
            wb[0].result = $random(seed);
            tick();
            offerRandomAll();
            offerUop[0].tagA = {1'b0, r};
            runIssue("reg read");
        end
        reportTest("reg read");
    endtask

    // Small tag range so writebacks, forwards and reads collide often
    task automatic testBypass();
        for (int k = 0; k < 8; k++) begin
            for (int w = 0; w < `NUM_WBS; w++) begin
                wbValid[w]   = 1'b1;
                wb[w].tagDst = 7'($random(seed) & 32'h7);
                wb[w].result = $random(seed);
            end
            zcValid[0]  = 1'b1;
            zcTag[0]    = wb[0].tagDst;
            zcResult[0] = $random(seed);
            // Odd rounds put both writebacks on one tag with the forward elsewhere
            if (k % 2 == 1) begin
                wb[`NUM_WBS-1].tagDst = wb[0].tagDst;
                zcTag[0]              = wb[0].tagDst ^ 7'h8;
            end
            offerRandomAll();
            offerUop[0].tagA = wb[0].tagDst;
            offerUop[0].tagB = wb[`NUM_WBS-1].tagDst;
            offerUop[1].tagA = 7'($random(seed) & 32'h7);
            offerUop[1].tagB = 7'($random(seed) & 32'h7);
            runIssue("bypass");
        end
        reportTest("bypass");
    endtask

    task automatic testImmediate();
        for (int k = 0; k < 8; k++) begin
            offerRandomAll();
            offerUop[0].tagA = {1'b1, 6'($random(seed))};
            offerUop[0].tagB = {1'b1, 6'($random(seed))};
            offerUop[1].tagA = {1'b1, 6'($random(seed))};
            offerUop[1].immB = 1'b1;
            runIssue("immediate");
        end
        reportTest("immediate");
    endtask

    task automatic testPcRebuild();
        for (int k = 0; k < 24; k++) begin
            pcWrite     = 1'b1;
            pcWriteAddr = 4'($random(seed));
            randomPcEntry(pcWriteData);
            offerRandomAll();
            // Hit the branch slot itself every other round
            if (k % 2 == 0) begin
                offerUop[1].fetchOffs = pcShadow[offerUop[1].fetchID].branchPos;
            end
            runIssue("pc rebuild");
        end
        reportTest("pc rebuild");
    endtask

    task automatic testStallInvalidate();
        uopPkg::IssueUop other;
        randomUop(offerUop[0]);
        offerUop[0].sqN = 7'd10;
        offerValid[0]   = 1'b1;
        runIssue("stall hold");
        randomUop(other);
        stallIn[0]  = 1'b1;
        uopValid[0] = 1'b1;
        uop[0]      = other;
        repeat (2) begin
            @(negedge clk);
            checkUop("stall hold", 0, lastExp[0]);
        end
        clearInputs();
        @(negedge clk);
        checkValid("stall hold", 0, 1'b0);

        // Both ports hold, invalidate sits between their sequence numbers
        randomUop(offerUop[0]);
        offerUop[0].sqN = 7'd10;
        offerValid[0]   = 1'b1;
        randomUop(offerUop[1]);
        offerUop[1].sqN = 7'd20;
        offerValid[1]   = 1'b1;
        runIssue("invalidate held");
        stallIn[0]    = 1'b1;
        stallIn[1]    = 1'b1;
        mispredict    = 1'b1;
        mispredictSqN = 7'd15;
        @(negedge clk);
        mispredict = 1'b0;
        @(negedge clk);
        checkUop("invalidate held", 0, lastExp[0]);
        checkValid("invalidate held", 1, 1'b0);
        clearInputs();
        waitRefillDone("invalidate held");

        // New uops offered in the invalidate cycle
        mispredict    = 1'b1;
        mispredictSqN = 7'd40;
        @(negedge clk);
        mispredict = 1'b0;
        offerRandomAll();
        offerUop[0].sqN = 7'd30;
        offerUop[1].sqN = 7'd50;
        expectDrop[1]   = 1'b1;
        runIssue("invalidate new");
        waitRefillDone("invalidate new");
        reportTest("stall/invalidate");
    endtask

    task automatic testRefill();
        uopPkg::ExecUop expU;
        int             idle;
        int             invalSeen;
        mispredict    = 1'b1;
        mispredictSqN = 7'd60;
        @(negedge clk);
        mispredict = 1'b0;
        invalSeen  = int'(opFetchTop_inst.invalidate);
        @(negedge clk);
        invalSeen += int'(opFetchTop_inst.invalidate);
        // Offered from the first refill cycle on
        randomUop(offerUop[0]);
        offerUop[0].sqN = 7'd55;
        uopValid[0]     = 1'b1;
        uop[0]          = offerUop[0];
        expU            = predictUop(offerUop[0]);
        commitShadow();
        idle = 0;
        for (int n = 0; n < 20; n++) begin
            @(negedge clk);
            invalSeen += int'(opFetchTop_inst.invalidate);
            if (execUop[0].valid) begin
                break;
            end
            idle++;
        end
        clearInputs();
        if (!execUop[0].valid) begin
            $display("[ERROR] refill: no valid output within 20 cycles after the window");
            errors++;
        end
        checkCount("refill invalidate cycles", 1, invalSeen);
        checkCount("refill stall cycles", `REFILL_CYCLES, idle);
        checkUop("refill", 0, expU);
        reportTest("refill");
    endtask

    initial begin
        seed            = 32'hd2adf959;
        errors          = 0;
        testStartErrors = 0;
        testsRun        = 0;
        testsFailed     = 0;
        clk             = 1'b0;
        rst             = 1'b1;
        for (int i = 0; i < `NUM_PORTS; i++) begin
            uop[i]        = '0;
            offerUop[i]   = '0;
            offerValid[i] = 1'b0;
            expectDrop[i] = 1'b0;
        end
        for (int w = 0; w < `NUM_WBS; w++) begin
            wb[w] = '0;
        end
        for (int z = 0; z < `NUM_ZC; z++) begin
            zcTag[z]    = '0;
            zcResult[z] = '0;
        end
        pcWriteAddr   = '0;
        pcWriteData   = '0;
        mispredictSqN = '0;
        clearInputs();
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        fillStores();
        testRegRead();
        testBypass();
        testImmediate();
        testPcRebuild();
        testStallInvalidate();
        testRefill();

        $display("tests run %0d, passed %0d, failed %0d, errors %0d",
                 testsRun, testsRun - testsFailed, testsFailed, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// ==== opFetchTop.sv ====
`include "opFetch_params.svh"

module opFetchTop (
    input  logic             clk,
    input  logic             rst,

    input  logic             uopValid[`NUM_PORTS-1:0],
    input  uopPkg::IssueUop  uop[`NUM_PORTS-1:0],
    input  logic             stallIn[`NUM_PORTS-1:0],

    input  logic             wbValid[`NUM_WBS-1:0],
    input  uopPkg::WbResult  wb[`NUM_WBS-1:0],

    input  logic             zcValid[`NUM_ZC-1:0],
    input  uopPkg::Tag       zcTag[`NUM_ZC-1:0],
    input  logic [31:0]      zcResult[`NUM_ZC-1:0],

    // Front-end PC file write
    input  logic             pcWrite,
    input  frontPkg::FetchId pcWriteAddr,
    input  frontPkg::PcEntry pcWriteData,

    input  logic             mispredict,
    input  uopPkg::SqN       mispredictSqN,

    output uopPkg::ExecUop   execUop[`NUM_PORTS-1:0]
);

    uopPkg::RegId     rfReadAddr[2*`NUM_PORTS-1:0];
    logic [31:0]      rfReadData[2*`NUM_PORTS-1:0];
    frontPkg::FetchId pcReadAddr[`NUM_PORTS-1:0];
    frontPkg::PcEntry pcReadData[`NUM_PORTS-1:0];

    uopPkg::RegId     rfWrAddr[`NUM_WBS-1:0];
    logic [31:0]      rfWrData[`NUM_WBS-1:0];
    logic             pcWrEn[0:0];
    frontPkg::FetchId pcWrAddr[0:0];
    frontPkg::PcEntry pcWrData[0:0];

    logic             invalidate;
    uopPkg::SqN       invalidateSqN;
    logic             stall[`NUM_PORTS-1:0];

    // Writebacks land in the register slot named by the tag
    for (genvar w = 0; w < `NUM_WBS; w++) begin : gWbWrite
        assign rfWrAddr[w] = wb[w].tagDst[5:0];
        assign rfWrData[w] = wb[w].result;
    end

    assign pcWrEn[0]   = pcWrite;
    assign pcWrAddr[0] = pcWriteAddr;
    assign pcWrData[0] = pcWriteData;

    portedStore #(
        .EntryT (logic [31:0]),
        .DEPTH  (`NUM_REGS),
        .NUM_RD (2 * `NUM_PORTS),
        .NUM_WR (`NUM_WBS)
    ) regFile (
        .clk    (clk),
        .rst    (rst),
        .wrEn   (wbValid),
        .wrAddr (rfWrAddr),
        .wrData (rfWrData),
        .rdAddr (rfReadAddr),
        .rdData (rfReadData)
    );

    portedStore #(
        .EntryT (frontPkg::PcEntry),
        .DEPTH  (`NUM_FETCH),
        .NUM_RD (`NUM_PORTS),
        .NUM_WR (1)
    ) pcFile (
        .clk    (clk),
        .rst    (rst),
        .wrEn   (pcWrEn),
        .wrAddr (pcWrAddr),
        .wrData (pcWrData),
        .rdAddr (pcReadAddr),
        .rdData (pcReadData)
    );

    flushCtrl flushCtrl_inst (
        .clk           (clk),
        .rst           (rst),
        .mispredict    (mispredict),
        .mispredictSqN (mispredictSqN),
        .stallIn       (stallIn),
        .invalidate    (invalidate),
        .invalidateSqN (invalidateSqN),
        .stall         (stall)
    );

    operandLoad operandLoad_inst (
        .clk           (clk),
        .rst           (rst),
        .uopValid      (uopValid),
        .uop           (uop),
        .wbValid       (wbValid),
        .wb            (wb),
        .zcValid       (zcValid),
        .zcTag         (zcTag),
        .zcResult      (zcResult),
        .invalidate    (invalidate),
        .invalidateSqN (invalidateSqN),
        .stall         (stall),
        .rfReadAddr    (rfReadAddr),
        .pcReadAddr    (pcReadAddr),
        .rfReadData    (rfReadData),
        .pcReadData    (pcReadData),
        .execUop       (execUop)
    );

endmodule

// ==== operandLoad.sv ====
`include "opFetch_params.svh"

module operandLoad (
    input  logic                 clk,
    input  logic                 rst,

    input  logic                 uopValid[`NUM_PORTS-1:0],
    input  uopPkg::IssueUop      uop[`NUM_PORTS-1:0],

    // Writeback snoop
    input  logic                 wbValid[`NUM_WBS-1:0],
    input  uopPkg::WbResult      wb[`NUM_WBS-1:0],

    // Zero-cycle forwards
    input  logic                 zcValid[`NUM_ZC-1:0],
    input  uopPkg::Tag           zcTag[`NUM_ZC-1:0],
    input  logic [31:0]          zcResult[`NUM_ZC-1:0],

    input  logic                 invalidate,
    input  uopPkg::SqN           invalidateSqN,
    input  logic                 stall[`NUM_PORTS-1:0],

    // Register file and PC file reads
    output uopPkg::RegId         rfReadAddr[2*`NUM_PORTS-1:0],
    output frontPkg::FetchId     pcReadAddr[`NUM_PORTS-1:0],
    input  logic [31:0]          rfReadData[2*`NUM_PORTS-1:0],
    input  frontPkg::PcEntry     pcReadData[`NUM_PORTS-1:0],

    output uopPkg::ExecUop       execUop[`NUM_PORTS-1:0]
);

    uopPkg::ExecUop nextUop[`NUM_PORTS-1:0];
    uopPkg::ExecUop uopQ[`NUM_PORTS-1:0];
    logic           validQ[`NUM_PORTS-1:0];
    logic           accept[`NUM_PORTS-1:0];

    // True when sqN is younger than the invalidating branch
    function automatic logic isYounger(input uopPkg::SqN sqN);
        return $signed(sqN - invalidateSqN) > 0;
    endfunction

    // Immediate, then zero-cycle forward, then writeback, then register file
    function automatic logic [31:0] fetchOperand(input uopPkg::Tag tag,
                                                 input logic [31:0] rfVal);
        logic [31:0] val;
        val = rfVal;
        for (int w = 0; w < `NUM_WBS; w++) begin
            if (wbValid[w] && wb[w].tagDst == tag) begin
                val = wb[w].result;
            end
        end
        for (int z = 0; z < `NUM_ZC; z++) begin
            if (zcValid[z] && zcTag[z] == tag) begin
                val = zcResult[z];
            end
        end
        if (tag[6]) begin
            val = {{26{tag[5]}}, tag[5:0]};
        end
        return val;
    endfunction

    always_comb begin
        for (int i = 0; i < `NUM_PORTS; i++) begin
            rfReadAddr[i]              = uop[i].tagA[5:0];
            rfReadAddr[i + `NUM_PORTS] = uop[i].tagB[5:0];
            pcReadAddr[i]              = uop[i].fetchID;
        end
    end

    always_comb begin
        for (int i = 0; i < `NUM_PORTS; i++) begin
            accept[i] = uopValid[i] && !stall[i]
                        && !(invalidate && isYounger(uop[i].sqN));

            nextUop[i]         = '0;
            nextUop[i].valid   = 1'b1;
            nextUop[i].imm     = uop[i].imm;
            nextUop[i].sqN     = uop[i].sqN;
            nextUop[i].tagDst  = uop[i].tagDst;
            nextUop[i].opcode  = uop[i].opcode;
            nextUop[i].fetchID = uop[i].fetchID;

            nextUop[i].srcA = fetchOperand(uop[i].tagA, rfReadData[i]);
            if (uop[i].immB) begin
                nextUop[i].srcB = uop[i].imm;
            end else begin
                nextUop[i].srcB = fetchOperand(uop[i].tagB, rfReadData[i + `NUM_PORTS]);
            end

            // Block base plus offset gives the end of the instruction
            nextUop[i].pc = {pcReadData[i].pc[30:3], uop[i].fetchOffs, 1'b0}
                            - (uop[i].compressed ? 32'd0 : 32'd2);

            // Past the predicted branch the history already includes its outcome
            if (pcReadData[i].bpi.predicted && !pcReadData[i].bpi.isJump
                    && uop[i].fetchOffs > pcReadData[i].branchPos) begin
                nextUop[i].history = {pcReadData[i].hist[$bits(frontPkg::BHist)-2:0],
                                      pcReadData[i].bpi.taken};
            end else begin
                nextUop[i].history = pcReadData[i].hist;
            end

            // Prediction only belongs to the branch slot itself
            if (uop[i].fetchOffs == pcReadData[i].branchPos) begin
                nextUop[i].bpi = pcReadData[i].bpi;
            end else begin
                nextUop[i].bpi = '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `NUM_PORTS; i++) begin
                validQ[i] <= 1'b0;
            end
        end else begin
            for (int i = 0; i < `NUM_PORTS; i++) begin
                if (accept[i]) begin
                    validQ[i] <= 1'b1;
                end else if (!stall[i]) begin
                    validQ[i] <= 1'b0;
                end else if (invalidate && isYounger(uopQ[i].sqN)) begin
                    // Held uop is on the wrong path
                    validQ[i] <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < `NUM_PORTS; i++) begin
            if (accept[i]) begin
                uopQ[i] <= nextUop[i];
            end
        end
    end

    always_comb begin
        for (int i = 0; i < `NUM_PORTS; i++) begin
            execUop[i]       = uopQ[i];
            execUop[i].valid = validQ[i];
        end
    end

endmodule

// ==== flushCtrl.sv ====
`include "opFetch_params.svh"

module flushCtrl (
    input  logic       clk,
    input  logic       rst,

    // Mispredict strobe from branch resolution
    input  logic       mispredict,
    input  uopPkg::SqN mispredictSqN,

    input  logic       stallIn[`NUM_PORTS-1:0],

    output logic       invalidate,
    output uopPkg::SqN invalidateSqN,
    output logic       stall[`NUM_PORTS-1:0]
);

    localparam int CNT_W = $clog2(`REFILL_CYCLES + 1);

    typedef enum logic [1:0] {
        IDLE,
        INVAL,
        REFILL
    } FlushState;

    FlushState        state;
    FlushState        stateNext;
    logic [CNT_W-1:0] refillCnt;

    always_comb begin
        stateNext = state;
        unique case (state)
            IDLE:   stateNext = IDLE;
            INVAL:  stateNext = REFILL;
            REFILL: begin
                if (refillCnt == CNT_W'(1)) begin
                    stateNext = IDLE;
                end
            end
            default: stateNext = IDLE;
        endcase
        // A new mispredict restarts the sequence from any state
        if (mispredict) begin
            stateNext = INVAL;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= IDLE;
            refillCnt <= '0;
        end else begin
            state <= stateNext;
            if (state == INVAL) begin
                refillCnt <= CNT_W'(`REFILL_CYCLES);
            end else if (state == REFILL) begin
                refillCnt <= refillCnt - CNT_W'(1);
            end
        end
    end

    // Sequence number of the branch that mispredicted
    always_ff @(posedge clk) begin
        if (mispredict) begin
            invalidateSqN <= mispredictSqN;
        end
    end

    assign invalidate = (state == INVAL);

    // Refill window holds every port on top of its own stall
    always_comb begin
        for (int i = 0; i < `NUM_PORTS; i++) begin
            stall[i] = stallIn[i] || (state == REFILL);
        end
    end

endmodule

// ==== portedStore.sv ====
module portedStore #(
    parameter type EntryT = logic [31:0],
    parameter int DEPTH = 64,
    parameter int NUM_RD = 2,
    parameter int NUM_WR = 1
) (
    input  logic clk,
    input  logic rst,

    // Write ports, applied at the rising edge
    input  logic                     wrEn[NUM_WR-1:0],
    input  logic [$clog2(DEPTH)-1:0] wrAddr[NUM_WR-1:0],
    input  EntryT                    wrData[NUM_WR-1:0],

    // Read ports, combinational
    input  logic [$clog2(DEPTH)-1:0] rdAddr[NUM_RD-1:0],
    output EntryT                    rdData[NUM_RD-1:0]
);

    EntryT mem[DEPTH-1:0];

    // Later ports override earlier ones on the same address
    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int w = 0; w < NUM_WR; w++) begin
                if (wrEn[w]) begin
                    mem[wrAddr[w]] <= wrData[w];
                end
            end
        end
    end

    // Reads see the contents before this cycle's writes
    always_comb begin
        for (int r = 0; r < NUM_RD; r++) begin
            rdData[r] = mem[rdAddr[r]];
        end
    end

endmodule

// ==== uopPkg.sv ====
package uopPkg;

    // Source or destination tag
    // Bit 6 set means bits 5..0 hold a signed inline immediate
    typedef logic [6:0] Tag;

    // Physical register number
    typedef logic [5:0] RegId;

    // Sequence number, ordered by signed difference
    typedef logic [6:0] SqN;

    // Micro-op as it leaves the issue queues
    typedef struct packed {
        Tag                tagA;
        Tag                tagB;
        Tag                tagDst;
        SqN                sqN;
        logic [31:0]       imm;
        logic [5:0]        opcode;
        frontPkg::FetchId  fetchID;
        // Halfword offset within the fetch block
        logic [2:0]        fetchOffs;
        logic              compressed;
        // Use imm instead of tagB for the second operand
        logic              immB;
    } IssueUop;

    // Micro-op with operands, handed to the execute units
    typedef struct packed {
        logic                valid;
        logic [31:0]         srcA;
        logic [31:0]         srcB;
        logic [31:0]         imm;
        SqN                  sqN;
        Tag                  tagDst;
        logic [5:0]          opcode;
        logic [31:0]         pc;
        frontPkg::FetchId    fetchID;
        frontPkg::BranchInfo bpi;
        frontPkg::BHist      history;
    } ExecUop;

    // Result broadcast from a writeback port
    typedef struct packed {
        Tag          tagDst;
        logic [31:0] result;
    } WbResult;

endpackage

// ==== frontPkg.sv ====
package frontPkg;

    // Index into the PC file
    typedef logic [3:0] FetchId;

    // Branch prediction bits as recorded by the front end
    typedef struct packed {
        logic predicted;
        logic taken;
        logic isJump;
    } BranchInfo;

    // Global branch history
    typedef logic [7:0] BHist;

    // One PC file entry per fetch block
    typedef struct packed {
        // Halfword address of the fetch block
        logic [30:0] pc;
        // Slot of the predicted branch within the block
        logic [2:0]  branchPos;
        BranchInfo   bpi;
        // History before the predicted branch
        BHist        hist;
    } PcEntry;

endpackage

// ==== opFetch_params.svh ====
`ifndef OPFETCH_PARAMS_SVH
`define OPFETCH_PARAMS_SVH

// Issue ports feeding the operand-fetch stage
`define NUM_PORTS 2

// Writeback ports snooped for bypass and written into the register file
`define NUM_WBS 2

// Zero-cycle forward ports from the execute units
`define NUM_ZC 1

// Physical integer registers
`define NUM_REGS 64

// PC file entries, one per fetch ID
`define NUM_FETCH 16

// Cycles of forced stall after the invalidate cycle
`define REFILL_CYCLES 4

`endif
